// File: hdl/floo_lite_pkg.sv
// Shared definitions for the AXI4-Lite network slice
// Holds mesh coordinates, flit and AXI4-Lite channel structs, enums,
// sizes and the address rule table used by route computation
package floo_lite_pkg;

  // Sizes used throughout the slice
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned NumRules  = 2;

  // The word index sits just above the byte offset and spans 3 bits
  localparam int unsigned WordIdxLsb = 2;

  // Address bits read when routing by address bits instead of the table
  localparam int unsigned IdBitsOffsetX = 8;
  localparam int unsigned IdBitsOffsetY = 10;

  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } coord_t;

  typedef enum logic {
    ROUTE_TABLE,
    ROUTE_ID_BITS
  } route_algo_e;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_WRITE_RSP,
    OP_READ_RSP
  } flit_op_e;

  // Encodings follow the AXI response field
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    coord_t               src;
    coord_t               dst;
    flit_op_e             op;
    axi_resp_e            resp;
    logic [2:0]           word_idx;
    logic [DataWidth-1:0] data;
    logic [3:0]           strb;
  } flit_t;

  // The end address is exclusive
  typedef struct packed {
    coord_t               dst;
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
  } rule_t;

  // Rule 0 is the east bank at (1,0) and rule 1 the north bank at (0,1)
  localparam rule_t [NumRules-1:0] AddrMap = '{
    '{dst: '{x: 2'd0, y: 2'd1}, start_addr: 16'h0100, end_addr: 16'h0120},
    '{dst: '{x: 2'd1, y: 2'd0}, start_addr: 16'h0000, end_addr: 16'h0020}
  };

  // The manager port and its chimney sit at the mesh origin
  localparam coord_t LocalCoord = '{x: 2'd0, y: 2'd0};

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [3:0]           strb;
  } axil_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    axi_resp_e            resp;
  } axil_r_t;

endpackage

// File: hdl/floo_route_comp.sv
// Route computation for request flits
// Maps an address to a destination mesh coordinate either through the
// rule table or by slicing coordinate fields out of the address
`timescale 1ns/100ps

module floo_route_comp #(
  parameter floo_lite_pkg::route_algo_e RouteAlgo = floo_lite_pkg::ROUTE_TABLE
) (
  input  logic [floo_lite_pkg::AddrWidth-1:0] addr_i,
  output floo_lite_pkg::coord_t               dst_o,
  output logic                                dec_error_o
);

  if (RouteAlgo == floo_lite_pkg::ROUTE_TABLE) begin : gen_table_routing
    // The table is scanned from the top down so the lowest matching rule
    // is the last one written and therefore wins
    always_comb begin
      dst_o       = '0;
      dec_error_o = 1'b1;
      for (int i = floo_lite_pkg::NumRules - 1; i >= 0; i--) begin
        if ((addr_i >= floo_lite_pkg::AddrMap[i].start_addr) &&
            (addr_i <  floo_lite_pkg::AddrMap[i].end_addr)) begin
          dst_o       = floo_lite_pkg::AddrMap[i].dst;
          dec_error_o = 1'b0;
        end
      end
    end
  end else begin : gen_id_bits_routing
    // The coordinate comes straight from the address
    assign dst_o.x = addr_i[floo_lite_pkg::IdBitsOffsetX +: $bits(dst_o.x)];
    assign dst_o.y = addr_i[floo_lite_pkg::IdBitsOffsetY +: $bits(dst_o.y)];
    // Every address decodes to some coordinate in this mode
    assign dec_error_o = 1'b0;
  end

endmodule

// File: hdl/floo_lite_chimney.sv
// AXI4-Lite network interface at node (0,0)
// Turns one write or read at a time into a request flit, answers
// unmapped addresses with DECERR itself, and returns response flits
// to the manager as B or R beats
`timescale 1ns/100ps

module floo_lite_chimney (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // AXI4-Lite subordinate port
  input  floo_lite_pkg::axil_aw_t   aw_i,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  floo_lite_pkg::axil_w_t    w_i,
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  output floo_lite_pkg::axil_b_t    b_o,
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  input  floo_lite_pkg::axil_ar_t   ar_i,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  output floo_lite_pkg::axil_r_t    r_o,
  output logic                      r_valid_o,
  input  logic                      r_ready_i,
  // Request flit link toward the node
  output floo_lite_pkg::flit_t      req_o,
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  // Response flit link from the node
  input  floo_lite_pkg::flit_t      rsp_i,
  input  logic                      rsp_valid_i,
  output logic                      rsp_ready_o
);

  typedef enum logic [2:0] {
    IDLE,
    SEND,
    WAIT_RSP,
    RESP_B,
    RESP_R
  } state_e;

  state_e                              state_q;
  floo_lite_pkg::flit_t                req_q;
  floo_lite_pkg::axil_b_t              b_q;
  floo_lite_pkg::axil_r_t              r_q;
  logic                                wr_both;
  logic                                take_write;
  logic                                take_read;
  logic [floo_lite_pkg::AddrWidth-1:0] addr;
  floo_lite_pkg::coord_t               dst;
  logic                                dec_error;

  // A write needs AW and W together and beats a read on the same cycle
  assign wr_both    = aw_valid_i && w_valid_i;
  assign take_write = (state_q == IDLE) && wr_both;
  assign take_read  = (state_q == IDLE) && !wr_both && ar_valid_i;

  // Route the address of whichever request is taken this cycle
  assign addr = wr_both ? aw_i.addr : ar_i.addr;

  floo_route_comp #(
    .RouteAlgo ( floo_lite_pkg::ROUTE_TABLE )
  ) i_route_comp (
    .addr_i      ( addr      ),
    .dst_o       ( dst       ),
    .dec_error_o ( dec_error )
  );

  // Address channels are open only between transactions
  assign aw_ready_o = (state_q == IDLE);
  assign w_ready_o  = (state_q == IDLE);
  assign ar_ready_o = (state_q == IDLE);

  assign req_o       = req_q;
  assign req_valid_o = (state_q == SEND);
  assign rsp_ready_o = (state_q == WAIT_RSP);

  assign b_o       = b_q;
  assign b_valid_o = (state_q == RESP_B);
  assign r_o       = r_q;
  assign r_valid_o = (state_q == RESP_R);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          // Unmapped addresses skip the network and answer directly
          if (take_write) begin
            state_q <= dec_error ? RESP_B : SEND;
          end else if (take_read) begin
            state_q <= dec_error ? RESP_R : SEND;
          end
        end
        SEND: begin
          if (req_ready_i) begin
            state_q <= WAIT_RSP;
          end
        end
        WAIT_RSP: begin
          if (rsp_valid_i) begin
            state_q <= (rsp_i.op == floo_lite_pkg::OP_WRITE_RSP) ? RESP_B : RESP_R;
          end
        end
        RESP_B: begin
          if (b_ready_i) begin
            state_q <= IDLE;
          end
        end
        RESP_R: begin
          if (r_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Flit and response payloads
  always_ff @(posedge clk_i) begin
    if (take_write || take_read) begin
      req_q.src      <= floo_lite_pkg::LocalCoord;
      req_q.dst      <= dst;
      req_q.op       <= take_write ? floo_lite_pkg::OP_WRITE : floo_lite_pkg::OP_READ;
      req_q.resp     <= floo_lite_pkg::RESP_OKAY;
      req_q.word_idx <= addr[floo_lite_pkg::WordIdxLsb +: 3];
      req_q.data     <= take_write ? w_i.data : '0;
      req_q.strb     <= take_write ? w_i.strb : '0;
    end
    // Preload DECERR, which only reaches the manager when no flit is sent
    if (take_write) begin
      b_q.resp <= floo_lite_pkg::RESP_DECERR;
    end
    if (take_read) begin
      r_q.data <= '0;
      r_q.resp <= floo_lite_pkg::RESP_DECERR;
    end
    // A returning flit overwrites the preloaded error
    if ((state_q == WAIT_RSP) && rsp_valid_i) begin
      b_q.resp <= rsp_i.resp;
      r_q.data <= rsp_i.data;
      r_q.resp <= rsp_i.resp;
    end
  end

  // The network must never return a flit that nobody is waiting for
  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |-> (state_q == WAIT_RSP));

endmodule

// File: hdl/floo_lite_node.sv
// Crossbar for node (0,0)
// Forks local requests east or north in XY order through one register
// stage and merges the two response streams back by round robin
`timescale 1ns/100ps

module floo_lite_node (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Local port toward the chimney
  input  floo_lite_pkg::flit_t loc_req_i,
  input  logic                 loc_req_valid_i,
  output logic                 loc_req_ready_o,
  output floo_lite_pkg::flit_t loc_rsp_o,
  output logic                 loc_rsp_valid_o,
  input  logic                 loc_rsp_ready_i,
  // East port toward node (1,0)
  output floo_lite_pkg::flit_t east_req_o,
  output logic                 east_req_valid_o,
  input  logic                 east_req_ready_i,
  input  floo_lite_pkg::flit_t east_rsp_i,
  input  logic                 east_rsp_valid_i,
  output logic                 east_rsp_ready_o,
  // North port toward node (0,1)
  output floo_lite_pkg::flit_t north_req_o,
  output logic                 north_req_valid_o,
  input  logic                 north_req_ready_i,
  input  floo_lite_pkg::flit_t north_rsp_i,
  input  logic                 north_rsp_valid_i,
  output logic                 north_rsp_ready_o
);

  floo_lite_pkg::flit_t req_q;
  logic                 req_valid_q;
  logic                 req_east_q;
  logic                 req_out_ready;
  floo_lite_pkg::flit_t rsp_q;
  logic                 rsp_valid_q;
  logic                 rsp_in_ready;
  logic                 rr_north_q;
  logic                 grant_east;
  logic                 grant_north;

  // X is resolved first, so any non-zero x leaves through the east port
  assign req_out_ready   = req_east_q ? east_req_ready_i : north_req_ready_i;
  assign loc_req_ready_o = !req_valid_q || req_out_ready;

  // Both ports see the same flit register and only one valid rises
  assign east_req_o        = req_q;
  assign north_req_o       = req_q;
  assign east_req_valid_o  = req_valid_q && req_east_q;
  assign north_req_valid_o = req_valid_q && !req_east_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_valid_q <= 1'b0;
    end else if (loc_req_ready_o) begin
      req_valid_q <= loc_req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (loc_req_valid_i && loc_req_ready_o) begin
      req_q      <= loc_req_i;
      req_east_q <= (loc_req_i.dst.x != 2'd0);
    end
  end

  // The pointer gives north priority right after an east grant and back
  assign grant_east  = east_rsp_valid_i && (!north_rsp_valid_i || !rr_north_q);
  assign grant_north = north_rsp_valid_i && !grant_east;

  assign rsp_in_ready      = !rsp_valid_q || loc_rsp_ready_i;
  assign east_rsp_ready_o  = rsp_in_ready && grant_east;
  assign north_rsp_ready_o = rsp_in_ready && grant_north;

  assign loc_rsp_o       = rsp_q;
  assign loc_rsp_valid_o = rsp_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rr_north_q  <= 1'b0;
    end else if (rsp_in_ready) begin
      rsp_valid_q <= grant_east || grant_north;
      if (grant_east || grant_north) begin
        rr_north_q <= grant_east;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_in_ready && (grant_east || grant_north)) begin
      rsp_q <= grant_east ? east_rsp_i : north_rsp_i;
    end
  end

  // The chimney decodes to a remote bank, so nothing may target this node
  assert property (@(posedge clk_i) disable iff (rst_i)
    loc_req_valid_i |-> (loc_req_i.dst != floo_lite_pkg::LocalCoord));

endmodule

// File: hdl/floo_lite_reg_endpoint.sv
// Register endpoint on a remote node
// Executes one request flit per cycle on an 8-word bank and sends the
// response flit back to the requester
`timescale 1ns/100ps

module floo_lite_reg_endpoint (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  floo_lite_pkg::flit_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output floo_lite_pkg::flit_t rsp_o,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i
);

  logic [floo_lite_pkg::DataWidth-1:0] mem_q [8];
  floo_lite_pkg::flit_t                rsp_q;
  logic                                rsp_valid_q;
  logic                                req_fire;
  logic                                is_write;

  // A new request fits when the response register is empty or draining
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;
  assign is_write    = (req_i.op == floo_lite_pkg::OP_WRITE);

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      for (int i = 0; i < 8; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (req_ready_o) begin
        rsp_valid_q <= req_valid_i;
      end
      // Only the byte lanes selected by the strobe change
      if (req_fire && is_write) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) begin
            mem_q[req_i.word_idx][8*b +: 8] <= req_i.data[8*b +: 8];
          end
        end
      end
    end
  end

  // The response swaps src and dst so it finds its way home
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q.src      <= req_i.dst;
      rsp_q.dst      <= req_i.src;
      rsp_q.op       <= is_write ? floo_lite_pkg::OP_WRITE_RSP : floo_lite_pkg::OP_READ_RSP;
      rsp_q.resp     <= floo_lite_pkg::RESP_OKAY;
      rsp_q.word_idx <= req_i.word_idx;
      rsp_q.data     <= is_write ? '0 : mem_q[req_i.word_idx];
      rsp_q.strb     <= '0;
    end
  end

  // Response opcodes must never travel on a request link
  assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> (req_i.op inside {floo_lite_pkg::OP_WRITE, floo_lite_pkg::OP_READ}));

endmodule

// File: hdl/floo_lite_top.sv
// Top level of the network slice
// Connects the chimney at (0,0) through the node crossbar to the
// register endpoints at (1,0) and (0,1)
`timescale 1ns/100ps

module floo_lite_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  floo_lite_pkg::axil_aw_t aw_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  floo_lite_pkg::axil_w_t  w_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output floo_lite_pkg::axil_b_t  b_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  input  floo_lite_pkg::axil_ar_t ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output floo_lite_pkg::axil_r_t  r_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i
);

  // Links between chimney and node
  floo_lite_pkg::flit_t loc_req, loc_rsp;
  logic                 loc_req_valid, loc_req_ready;
  logic                 loc_rsp_valid, loc_rsp_ready;
  // Links between node and the east endpoint
  floo_lite_pkg::flit_t east_req, east_rsp;
  logic                 east_req_valid, east_req_ready;
  logic                 east_rsp_valid, east_rsp_ready;
  // Links between node and the north endpoint
  floo_lite_pkg::flit_t north_req, north_rsp;
  logic                 north_req_valid, north_req_ready;
  logic                 north_rsp_valid, north_rsp_ready;

  floo_lite_chimney i_chimney (
    .clk_i, .rst_i,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .r_o, .r_valid_o, .r_ready_i,
    .req_o       ( loc_req       ),
    .req_valid_o ( loc_req_valid ),
    .req_ready_i ( loc_req_ready ),
    .rsp_i       ( loc_rsp       ),
    .rsp_valid_i ( loc_rsp_valid ),
    .rsp_ready_o ( loc_rsp_ready )
  );

  floo_lite_node i_node (
    .clk_i, .rst_i,
    .loc_req_i         ( loc_req         ),
    .loc_req_valid_i   ( loc_req_valid   ),
    .loc_req_ready_o   ( loc_req_ready   ),
    .loc_rsp_o         ( loc_rsp         ),
    .loc_rsp_valid_o   ( loc_rsp_valid   ),
    .loc_rsp_ready_i   ( loc_rsp_ready   ),
    .east_req_o        ( east_req        ),
    .east_req_valid_o  ( east_req_valid  ),
    .east_req_ready_i  ( east_req_ready  ),
    .east_rsp_i        ( east_rsp        ),
    .east_rsp_valid_i  ( east_rsp_valid  ),
    .east_rsp_ready_o  ( east_rsp_ready  ),
    .north_req_o       ( north_req       ),
    .north_req_valid_o ( north_req_valid ),
    .north_req_ready_i ( north_req_ready ),
    .north_rsp_i       ( north_rsp       ),
    .north_rsp_valid_i ( north_rsp_valid ),
    .north_rsp_ready_o ( north_rsp_ready )
  );

  floo_lite_reg_endpoint i_ep_east (
    .clk_i, .rst_i,
    .req_i       ( east_req       ),
    .req_valid_i ( east_req_valid ),
    .req_ready_o ( east_req_ready ),
    .rsp_o       ( east_rsp       ),
    .rsp_valid_o ( east_rsp_valid ),
    .rsp_ready_i ( east_rsp_ready )
  );

  floo_lite_reg_endpoint i_ep_north (
    .clk_i, .rst_i,
    .req_i       ( north_req       ),
    .req_valid_i ( north_req_valid ),
    .req_ready_o ( north_req_ready ),
    .rsp_o       ( north_rsp       ),
    .rsp_valid_o ( north_rsp_valid ),
    .rsp_ready_i ( north_rsp_ready )
  );

endmodule

// File: testbench/floo_lite_tb.sv
// Testbench for the AXI4-Lite network slice
// Runs a table of writes and reads through the chimney and checks every
// B and R beat against a reference model of the two remote register banks
`timescale 1ns/100ps

module floo_lite_tb;

  // One table row is one AXI4-Lite transaction
  typedef struct packed {
    logic                                is_read;
    logic [floo_lite_pkg::AddrWidth-1:0] addr;
    logic [floo_lite_pkg::DataWidth-1:0] data;
    logic [3:0]                          strb;
    logic [3:0]                          stall;
    logic                                w_lag;
  } stim_t;

  logic                    clk;
  logic                    rst;
  floo_lite_pkg::axil_aw_t aw;
  logic                    aw_valid;
  logic                    aw_ready;
  floo_lite_pkg::axil_w_t  w;
  logic                    w_valid;
  logic                    w_ready;
  floo_lite_pkg::axil_b_t  b;
  logic                    b_valid;
  logic                    b_ready;
  floo_lite_pkg::axil_ar_t ar;
  logic                    ar_valid;
  logic                    ar_ready;
  floo_lite_pkg::axil_r_t  r;
  logic                    r_valid;
  logic                    r_ready;

  stim_t                               stim_q[$];
  logic [floo_lite_pkg::DataWidth-1:0] east_bank [8];
  logic [floo_lite_pkg::DataWidth-1:0] north_bank [8];
  int                                  seed;
  int unsigned                         n_checks;
  int unsigned                         n_errors;
  int unsigned                         cycle_count = 0;
  int unsigned                         timeout_limit = 0;

  floo_lite_top UUT (
    .clk_i      ( clk      ),
    .rst_i      ( rst      ),
    .aw_i       ( aw       ),
    .aw_valid_i ( aw_valid ),
    .aw_ready_o ( aw_ready ),
    .w_i        ( w        ),
    .w_valid_i  ( w_valid  ),
    .w_ready_o  ( w_ready  ),
    .b_o        ( b        ),
    .b_valid_o  ( b_valid  ),
    .b_ready_i  ( b_ready  ),
    .ar_i       ( ar       ),
    .ar_valid_i ( ar_valid ),
    .ar_ready_o ( ar_ready ),
    .r_o        ( r        ),
    .r_valid_o  ( r_valid  ),
    .r_ready_i  ( r_ready  )
  );

  always #2 clk = ~clk;

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    n_checks++;
    if (act_val !== exp_val) begin
      n_errors++;
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_resp(input string name, input floo_lite_pkg::axi_resp_e exp_val,
                            input floo_lite_pkg::axi_resp_e act_val);
    n_checks++;
    if (act_val !== exp_val) begin
      n_errors++;
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
    n_checks++;
    if (act_val !== exp_val) begin
      n_errors++;
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
    end
  endtask

  // Bank 0 is east at (1,0), bank 1 is north at (0,1), -1 means unmapped
  function automatic int model_bank(input logic [15:0] addr);
    for (int i = 0; i < floo_lite_pkg::NumRules; i++) begin
      if ((addr >= floo_lite_pkg::AddrMap[i].start_addr) &&
          (addr < floo_lite_pkg::AddrMap[i].end_addr)) begin
        return (floo_lite_pkg::AddrMap[i].dst.x != 2'd0) ? 0 : 1;
      end
    end
    return -1;
  endfunction

  function automatic logic [31:0] strb_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic add_entry(input logic is_read, input logic [15:0] addr,
                           input logic [3:0] strb, input logic [3:0] stall,
                           input logic w_lag);
    stim_t s;
    s.is_read = is_read;
    s.addr    = addr;
    s.data    = $random(seed);
    s.strb    = strb;
    s.stall   = stall;
    s.w_lag   = w_lag;
    stim_q.push_back(s);
  endtask

  task automatic build_table();
    // Full writes and readback on the east bank, then the north bank
    add_entry(1'b0, 16'h0004, 4'hf, 4'd0, 1'b0);
    add_entry(1'b1, 16'h0004, 4'h0, 4'd0, 1'b0);
    add_entry(1'b1, 16'h0008, 4'h0, 4'd0, 1'b0);
    add_entry(1'b0, 16'h0104, 4'hf, 4'd0, 1'b0);
    add_entry(1'b1, 16'h0104, 4'h0, 4'd0, 1'b0);
    add_entry(1'b1, 16'h0004, 4'h0, 4'd0, 1'b0);
    // Partial strobes merge into existing and zero words
    add_entry(1'b0, 16'h0004, 4'h5, 4'd0, 1'b0);
    add_entry(1'b1, 16'h0004, 4'h0, 4'd0, 1'b0);
    add_entry(1'b0, 16'h010c, 4'h8, 4'd0, 1'b0);
    add_entry(1'b1, 16'h010c, 4'h0, 4'd0, 1'b0);
    // Unmapped addresses, including the exclusive end of the east rule
    add_entry(1'b0, 16'h0080, 4'hf, 4'd0, 1'b0);
    add_entry(1'b1, 16'h0080, 4'h0, 4'd0, 1'b0);
    add_entry(1'b1, 16'h0020, 4'h0, 4'd2, 1'b0);
    // Back-pressure on B and R
    add_entry(1'b0, 16'h001c, 4'hf, 4'd4, 1'b0);
    add_entry(1'b1, 16'h001c, 4'h0, 4'd3, 1'b0);
    // W one cycle behind AW
    add_entry(1'b0, 16'h0110, 4'hf, 4'd0, 1'b1);
    add_entry(1'b1, 16'h0110, 4'h0, 4'd0, 1'b0);
    add_entry(1'b0, 16'h0000, 4'h3, 4'd2, 1'b1);
    // Sweep both banks so untouched words are seen too
    for (int i = 0; i < 8; i++) begin
      add_entry(1'b1, 16'h0000 + 16'(4 * i), 4'h0, 4'd0, 1'b0);
      add_entry(1'b1, 16'h0100 + 16'(4 * i), 4'h0, 4'd0, 1'b0);
    end
  endtask

  task automatic do_write(input stim_t s);
    int                       bank;
    logic [2:0]               idx;
    logic [31:0]              mask;
    floo_lite_pkg::axi_resp_e exp_resp;
    floo_lite_pkg::axil_b_t   held;
    bank = model_bank(s.addr);
    idx  = s.addr[floo_lite_pkg::WordIdxLsb +: 3];
    mask = strb_mask(s.strb);
    if (bank < 0) begin
      exp_resp = floo_lite_pkg::RESP_DECERR;
    end else begin
      exp_resp = floo_lite_pkg::RESP_OKAY;
    end
    aw.addr  = s.addr;
    aw_valid = 1'b1;
    w.data   = s.data;
    w.strb   = s.strb;
    if (s.w_lag) begin
      // AW alone over one edge must leave the chimney idle
      @(posedge clk);
      #1;
      check_bit("aw_ready_o", 1'b1, aw_ready);
      check_bit("w_ready_o", 1'b1, w_ready);
      check_bit("b_valid_o", 1'b0, b_valid);
    end
    w_valid = 1'b1;
    while (!(aw_ready && w_ready)) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    while (!b_valid) begin
      @(posedge clk);
      #1;
    end
    held = b;
    // B must hold still and nothing new may enter while it waits
    repeat (s.stall) begin
      @(posedge clk);
      #1;
      check_bit("b_valid_o", 1'b1, b_valid);
      check_resp("b_o.resp", held.resp, b.resp);
      check_bit("aw_ready_o", 1'b0, aw_ready);
      check_bit("w_ready_o", 1'b0, w_ready);
      check_bit("ar_ready_o", 1'b0, ar_ready);
    end
    check_resp("b_o.resp", exp_resp, b.resp);
    b_ready = 1'b1;
    @(posedge clk);
    #1;
    b_ready = 1'b0;
    check_bit("b_valid_o", 1'b0, b_valid);
    if (bank == 0) begin
      east_bank[idx] = (east_bank[idx] & ~mask) | (s.data & mask);
    end else if (bank == 1) begin
      north_bank[idx] = (north_bank[idx] & ~mask) | (s.data & mask);
    end
  endtask

  task automatic do_read(input stim_t s);
    int                       bank;
    logic [2:0]               idx;
    logic [31:0]              exp_data;
    floo_lite_pkg::axi_resp_e exp_resp;
    floo_lite_pkg::axil_r_t   held;
    bank = model_bank(s.addr);
    idx  = s.addr[floo_lite_pkg::WordIdxLsb +: 3];
    exp_resp = floo_lite_pkg::RESP_OKAY;
    if (bank == 0) begin
      exp_data = east_bank[idx];
    end else if (bank == 1) begin
      exp_data = north_bank[idx];
    end else begin
      // Unmapped reads come back as DECERR with zero data
      exp_data = '0;
      exp_resp = floo_lite_pkg::RESP_DECERR;
    end
    ar.addr  = s.addr;
    ar_valid = 1'b1;
    while (!ar_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
    while (!r_valid) begin
      @(posedge clk);
      #1;
    end
    held = r;
    repeat (s.stall) begin
      @(posedge clk);
      #1;
      check_bit("r_valid_o", 1'b1, r_valid);
      check_data("r_o.data", held.data, r.data);
      check_resp("r_o.resp", held.resp, r.resp);
      check_bit("aw_ready_o", 1'b0, aw_ready);
      check_bit("w_ready_o", 1'b0, w_ready);
      check_bit("ar_ready_o", 1'b0, ar_ready);
    end
    check_data("r_o.data", exp_data, r.data);
    check_resp("r_o.resp", exp_resp, r.resp);
    r_ready = 1'b1;
    @(posedge clk);
    #1;
    r_ready = 1'b0;
    check_bit("r_valid_o", 1'b0, r_valid);
  endtask

  // Ends the run if any transaction stalls for good
  initial begin : watchdog
    wait (timeout_limit != 0);
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: transaction did not complete");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main
    clk      = 1'b0;
    rst      = 1'b1;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    seed     = 32'hd7a1;
    n_checks = 0;
    n_errors = 0;
    for (int k = 0; k < 8; k++) begin
      east_bank[k]  = '0;
      north_bank[k] = '0;
    end
    build_table();
    timeout_limit = stim_q.size() * 40;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // Only the address and write channels are ready after reset
    check_bit("aw_ready_o", 1'b1, aw_ready);
    check_bit("w_ready_o", 1'b1, w_ready);
    check_bit("ar_ready_o", 1'b1, ar_ready);
    check_bit("b_valid_o", 1'b0, b_valid);
    check_bit("r_valid_o", 1'b0, r_valid);
    foreach (stim_q[n]) begin
      if (stim_q[n].is_read) begin
        do_read(stim_q[n]);
      end else begin
        do_write(stim_q[n]);
      end
    end
    $display("checks: %0d errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
hdl/floo_lite_pkg.sv
hdl/floo_route_comp.sv
hdl/floo_lite_chimney.sv
hdl/floo_lite_node.sv
hdl/floo_lite_reg_endpoint.sv
hdl/floo_lite_top.sv
testbench/floo_lite_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -O2
TOP       := floo_lite_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
